/* design/cekirdek_cfg.svh */
`ifndef CEKIRDEK_CFG_SVH
`define CEKIRDEK_CFG_SVH

// Program counter and address width
`define CEKIRDEK_PS_BIT             32

// Data and instruction word width
`define CEKIRDEK_VERI_BIT           32

// Register file, x0 reads as zero
`define CEKIRDEK_YAZMAC_SAYISI      32
`define CEKIRDEK_YAZMAC_BIT         5

// First fetch address after reset
`define CEKIRDEK_RESET_PS           32'h0000_0000

`endif

/* design/cekirdek_pkg.sv */
`include "cekirdek_cfg.svh"

package cekirdek_pkg;

// Micro-op opcodes, anything undecodable becomes a NOP
typedef enum logic [3:0] {
    ISLEM_ADD,
    ISLEM_SUB,
    ISLEM_AND,
    ISLEM_OR,
    ISLEM_XOR,
    ISLEM_SLT,
    ISLEM_ADDI,
    ISLEM_BEQ,
    ISLEM_BNE,
    ISLEM_JAL,
    ISLEM_SW,
    ISLEM_NOP
} islem_e;

// GETIR_AT waits for a response that gets thrown away
typedef enum logic [1:0] {
    GETIR_BOSTA,
    GETIR_BEKLE,
    GETIR_AT
} getir_durum_e;

typedef struct packed {
    logic [`CEKIRDEK_VERI_BIT-1:0]      buyruk;
    logic [`CEKIRDEK_PS_BIT-1:0]        ps;
} buyruk_t;

typedef struct packed {
    logic                               gecerli;
    islem_e                             islem;
    logic [`CEKIRDEK_YAZMAC_BIT-1:0]    rd;
    logic [`CEKIRDEK_YAZMAC_BIT-1:0]    rs1;
    logic [`CEKIRDEK_YAZMAC_BIT-1:0]    rs2;
    logic [`CEKIRDEK_VERI_BIT-1:0]      imm;
    logic [`CEKIRDEK_PS_BIT-1:0]        ps;
} uop_t;

typedef struct packed {
    uop_t                               uop;
    logic [`CEKIRDEK_VERI_BIT-1:0]      rs1_veri;
    logic [`CEKIRDEK_VERI_BIT-1:0]      rs2_veri;
} yurut_uop_t;

typedef struct packed {
    logic                               gecerli;
    logic [`CEKIRDEK_YAZMAC_BIT-1:0]    rd;
    logic [`CEKIRDEK_VERI_BIT-1:0]      veri;
} geri_yaz_t;

typedef struct packed {
    logic                               gecerli;
    logic [`CEKIRDEK_PS_BIT-1:0]        ps;
} yonlendir_t;

endpackage

/* design/getir.sv */
`timescale 1ns/100ps

`include "cekirdek_cfg.svh"

module getir import cekirdek_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            duraklat_i,
    input  yonlendir_t                      yonlendir_i,

    output logic [`CEKIRDEK_PS_BIT-1:0]     buyruk_istek_adres_o,
    output logic                            buyruk_istek_gecerli_o,
    input  logic                            buyruk_istek_hazir_i,

    input  logic [`CEKIRDEK_VERI_BIT-1:0]   buyruk_yanit_veri_i,
    input  logic                            buyruk_yanit_gecerli_i,
    output logic                            buyruk_yanit_hazir_o,

    output buyruk_t                         buyruk_o,
    output logic                            buyruk_gecerli_o
);

getir_durum_e                   durum_q;
logic [`CEKIRDEK_PS_BIT-1:0]    ps_q;
logic [`CEKIRDEK_PS_BIT-1:0]    ps_d;
logic [`CEKIRDEK_PS_BIT-1:0]    istek_adres_q;
logic                           istek_gecerli_q;
logic                           istek_tamam;
logic                           yanit_tamam;
logic                           istek_baslat;

assign istek_tamam = istek_gecerli_q && buyruk_istek_hazir_i;

// A stall holds a live response but a discarded one is taken at once
assign buyruk_yanit_hazir_o = (durum_q == GETIR_AT) ||
                              ((durum_q == GETIR_BEKLE) && !duraklat_i);
assign yanit_tamam = buyruk_yanit_gecerli_i && buyruk_yanit_hazir_o;

// New request right after reset, or once the previous response is in
assign istek_baslat = !istek_gecerli_q &&
                      ((durum_q == GETIR_BOSTA) || yanit_tamam);

always_comb begin
    ps_d = ps_q;
    if (yonlendir_i.gecerli) begin
        ps_d = yonlendir_i.ps;
    end else if ((durum_q == GETIR_BEKLE) && yanit_tamam) begin
        ps_d = ps_q + 'd4;
    end
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        durum_q         <= GETIR_BOSTA;
        istek_gecerli_q <= 1'b0;
        ps_q            <= `CEKIRDEK_RESET_PS;
    end else begin
        ps_q <= ps_d;
        if (istek_baslat) begin
            istek_gecerli_q <= 1'b1;
        end else if (istek_tamam) begin
            istek_gecerli_q <= 1'b0;
        end
        case (durum_q)
            GETIR_BOSTA: begin
                if (istek_tamam) begin
                    durum_q <= yonlendir_i.gecerli ? GETIR_AT : GETIR_BEKLE;
                end else if (istek_gecerli_q && yonlendir_i.gecerli) begin
                    // Pending request cannot be withdrawn
                    durum_q <= GETIR_AT;
                end
            end
            GETIR_BEKLE: begin
                if (yanit_tamam) begin
                    durum_q <= GETIR_BOSTA;
                end else if (yonlendir_i.gecerli) begin
                    durum_q <= GETIR_AT;
                end
            end
            GETIR_AT: begin
                if (yanit_tamam && !istek_gecerli_q) begin
                    durum_q <= GETIR_BOSTA;
                end
            end
            default: durum_q <= GETIR_BOSTA;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (istek_baslat) begin
        istek_adres_q <= ps_d;
    end
end

assign buyruk_istek_adres_o   = istek_adres_q;
assign buyruk_istek_gecerli_o = istek_gecerli_q;

assign buyruk_o.buyruk  = buyruk_yanit_veri_i;
assign buyruk_o.ps      = istek_adres_q;
assign buyruk_gecerli_o = (durum_q == GETIR_BEKLE) && yanit_tamam;

// A response held back by getir must wait unchanged
yanit_sabit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    buyruk_yanit_gecerli_i && !buyruk_yanit_hazir_o |=>
        buyruk_yanit_gecerli_i && $stable(buyruk_yanit_veri_i));

endmodule

/* design/coz.sv */
`timescale 1ns/100ps

`include "cekirdek_cfg.svh"

module coz import cekirdek_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        duraklat_i,
    input  logic        bosalt_i,
    input  buyruk_t     buyruk_i,
    input  logic        buyruk_gecerli_i,
    output uop_t        uop_o
);

// RV32I major opcodes
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_DAL    = 7'b1100011;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_SAKLA  = 7'b0100011;

logic [`CEKIRDEK_VERI_BIT-1:0]  b;
logic [6:0]                     opcode;
logic [2:0]                     funct3;
logic [6:0]                     funct7;
logic [`CEKIRDEK_VERI_BIT-1:0]  i_imm;
logic [`CEKIRDEK_VERI_BIT-1:0]  s_imm;
logic [`CEKIRDEK_VERI_BIT-1:0]  b_imm;
logic [`CEKIRDEK_VERI_BIT-1:0]  j_imm;
uop_t                           uop_d;
uop_t                           uop_q;

assign b      = buyruk_i.buyruk;
assign opcode = b[6:0];
assign funct3 = b[14:12];
assign funct7 = b[31:25];

assign i_imm = {{20{b[31]}}, b[31:20]};
assign s_imm = {{20{b[31]}}, b[31:25], b[11:7]};
assign b_imm = {{19{b[31]}}, b[31], b[7], b[30:25], b[11:8], 1'b0};
assign j_imm = {{11{b[31]}}, b[31], b[19:12], b[20], b[30:21], 1'b0};

always_comb begin
    uop_d.gecerli = buyruk_gecerli_i;
    uop_d.islem   = ISLEM_NOP;
    uop_d.rd      = b[11:7];
    uop_d.rs1     = b[19:15];
    uop_d.rs2     = b[24:20];
    uop_d.imm     = i_imm;
    uop_d.ps      = buyruk_i.ps;
    case (opcode)
        OPC_OP: begin
            if (funct7 == 7'b0000000) begin
                case (funct3)
                    3'b000:  uop_d.islem = ISLEM_ADD;
                    3'b010:  uop_d.islem = ISLEM_SLT;
                    3'b100:  uop_d.islem = ISLEM_XOR;
                    3'b110:  uop_d.islem = ISLEM_OR;
                    3'b111:  uop_d.islem = ISLEM_AND;
                    default: uop_d.islem = ISLEM_NOP;
                endcase
            end else if ((funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
                uop_d.islem = ISLEM_SUB;
            end
        end
        OPC_OP_IMM: begin
            if (funct3 == 3'b000) begin
                uop_d.islem = ISLEM_ADDI;
            end
        end
        OPC_DAL: begin
            uop_d.imm = b_imm;
            if (funct3 == 3'b000) begin
                uop_d.islem = ISLEM_BEQ;
            end else if (funct3 == 3'b001) begin
                uop_d.islem = ISLEM_BNE;
            end
        end
        OPC_JAL: begin
            uop_d.imm   = j_imm;
            uop_d.islem = ISLEM_JAL;
        end
        OPC_SAKLA: begin
            uop_d.imm = s_imm;
            if (funct3 == 3'b010) begin
                uop_d.islem = ISLEM_SW;
            end
        end
        default: uop_d.islem = ISLEM_NOP;
    endcase
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i || bosalt_i) begin
        uop_q.gecerli <= 1'b0;
        uop_q.islem   <= ISLEM_NOP;
    end else if (!duraklat_i) begin
        uop_q <= uop_d;
    end
end

assign uop_o = uop_q;

endmodule

/* design/yazmac_oku.sv */
`timescale 1ns/100ps

`include "cekirdek_cfg.svh"

module yazmac_oku import cekirdek_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        duraklat_i,
    input  logic        bosalt_i,
    input  uop_t        uop_i,
    input  geri_yaz_t   geri_yaz_i,
    output yurut_uop_t  yurut_uop_o
);

logic [`CEKIRDEK_VERI_BIT-1:0]  yazmac_q [`CEKIRDEK_YAZMAC_SAYISI];
logic [`CEKIRDEK_VERI_BIT-1:0]  rs1_veri;
logic [`CEKIRDEK_VERI_BIT-1:0]  rs2_veri;
yurut_uop_t                     yurut_uop_q;

// Same-cycle writeback wins over the stored value
function automatic logic [`CEKIRDEK_VERI_BIT-1:0] oku(
    input logic [`CEKIRDEK_YAZMAC_BIT-1:0] idx
);
    logic [`CEKIRDEK_VERI_BIT-1:0] veri;
    veri = yazmac_q[idx];
    if (idx == '0) begin
        veri = '0;
    end else if (geri_yaz_i.gecerli && (geri_yaz_i.rd == idx)) begin
        veri = geri_yaz_i.veri;
    end
    return veri;
endfunction

always_ff @(posedge clk_i) begin
    if (geri_yaz_i.gecerli && (geri_yaz_i.rd != '0)) begin
        yazmac_q[geri_yaz_i.rd] <= geri_yaz_i.veri;
    end
end

assign rs1_veri = oku(uop_i.rs1);
assign rs2_veri = oku(uop_i.rs2);

always_ff @(posedge clk_i) begin
    if (!rst_n_i || bosalt_i) begin
        yurut_uop_q.uop.gecerli <= 1'b0;
        yurut_uop_q.uop.islem   <= ISLEM_NOP;
    end else if (!duraklat_i) begin
        yurut_uop_q.uop      <= uop_i;
        yurut_uop_q.rs1_veri <= rs1_veri;
        yurut_uop_q.rs2_veri <= rs2_veri;
    end
end

assign yurut_uop_o = yurut_uop_q;

endmodule

/* design/yurut.sv */
`timescale 1ns/100ps

`include "cekirdek_cfg.svh"

module yurut import cekirdek_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  yurut_uop_t                      yurut_uop_i,

    output logic [`CEKIRDEK_PS_BIT-1:0]     l1v_istek_adres_o,
    output logic [`CEKIRDEK_VERI_BIT-1:0]   l1v_istek_veri_o,
    output logic                            l1v_istek_gecerli_o,
    input  logic                            l1v_istek_hazir_i,

    output logic                            duraklat_o,
    output geri_yaz_t                       geri_yaz_o,
    output yonlendir_t                      yonlendir_o
);

uop_t                           uop;
logic [`CEKIRDEK_VERI_BIT-1:0]  a;
logic [`CEKIRDEK_VERI_BIT-1:0]  b;
logic [`CEKIRDEK_VERI_BIT-1:0]  sonuc;
logic                           atla;
logic                           yazar;
logic                           sakla;

assign uop = yurut_uop_i.uop;
assign a   = yurut_uop_i.rs1_veri;
assign b   = (uop.islem == ISLEM_ADDI) ? uop.imm : yurut_uop_i.rs2_veri;

always_comb begin
    sonuc = '0;
    atla  = 1'b0;
    yazar = 1'b0;
    case (uop.islem)
        ISLEM_ADD, ISLEM_ADDI: begin
            sonuc = a + b;
            yazar = 1'b1;
        end
        ISLEM_SUB: begin
            sonuc = a - b;
            yazar = 1'b1;
        end
        ISLEM_AND: begin
            sonuc = a & b;
            yazar = 1'b1;
        end
        ISLEM_OR: begin
            sonuc = a | b;
            yazar = 1'b1;
        end
        ISLEM_XOR: begin
            sonuc = a ^ b;
            yazar = 1'b1;
        end
        ISLEM_SLT: begin
            sonuc = {{(`CEKIRDEK_VERI_BIT-1){1'b0}}, $signed(a) < $signed(b)};
            yazar = 1'b1;
        end
        ISLEM_BEQ: atla = (a == b);
        ISLEM_BNE: atla = (a != b);
        ISLEM_JAL: begin
            // Link value is the fall-through address
            sonuc = uop.ps + 'd4;
            yazar = 1'b1;
            atla  = 1'b1;
        end
        default: sonuc = '0;
    endcase
end

assign geri_yaz_o.gecerli = uop.gecerli && yazar;
assign geri_yaz_o.rd      = uop.rd;
assign geri_yaz_o.veri    = sonuc;

// Not-taken prediction, so every taken branch redirects
assign yonlendir_o.gecerli = uop.gecerli && atla;
assign yonlendir_o.ps      = uop.ps + uop.imm;

assign sakla               = uop.gecerli && (uop.islem == ISLEM_SW);
assign l1v_istek_gecerli_o = sakla;
assign l1v_istek_adres_o   = a + uop.imm;
assign l1v_istek_veri_o    = yurut_uop_i.rs2_veri;
assign duraklat_o          = sakla && !l1v_istek_hazir_i;

// Held only if the whole pipeline really freezes behind the store
sakla_sabit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    l1v_istek_gecerli_o && !l1v_istek_hazir_i |=>
        l1v_istek_gecerli_o && $stable(l1v_istek_adres_o) &&
        $stable(l1v_istek_veri_o));

endmodule

/* design/cekirdek.sv */
`timescale 1ns/100ps

`include "cekirdek_cfg.svh"

module cekirdek import cekirdek_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Instruction memory
    input  logic [`CEKIRDEK_VERI_BIT-1:0]   buyruk_yanit_veri_i,
    input  logic                            buyruk_yanit_gecerli_i,
    output logic                            buyruk_yanit_hazir_o,

    output logic [`CEKIRDEK_PS_BIT-1:0]     buyruk_istek_adres_o,
    output logic                            buyruk_istek_gecerli_o,
    input  logic                            buyruk_istek_hazir_i,

    // Store port
    output logic [`CEKIRDEK_PS_BIT-1:0]     l1v_istek_adres_o,
    output logic [`CEKIRDEK_VERI_BIT-1:0]   l1v_istek_veri_o,
    output logic                            l1v_istek_gecerli_o,
    input  logic                            l1v_istek_hazir_i
);

buyruk_t        getir_buyruk_w;
logic           getir_buyruk_gecerli_w;
uop_t           coz_uop_w;
yurut_uop_t     yo_yurut_uop_w;
geri_yaz_t      yurut_geri_yaz_w;
yonlendir_t     yurut_yonlendir_w;
logic           yurut_duraklat_w;
logic           duraklat_w;
logic           bosalt_w;

// Only a waiting store stalls, and it freezes every stage
assign duraklat_w = yurut_duraklat_w;
assign bosalt_w   = yurut_yonlendir_w.gecerli;

getir getir (
    .clk_i                      ( clk_i ),
    .rst_n_i                    ( rst_n_i ),
    .duraklat_i                 ( duraklat_w ),
    .yonlendir_i                ( yurut_yonlendir_w ),
    .buyruk_istek_adres_o       ( buyruk_istek_adres_o ),
    .buyruk_istek_gecerli_o     ( buyruk_istek_gecerli_o ),
    .buyruk_istek_hazir_i       ( buyruk_istek_hazir_i ),
    .buyruk_yanit_veri_i        ( buyruk_yanit_veri_i ),
    .buyruk_yanit_gecerli_i     ( buyruk_yanit_gecerli_i ),
    .buyruk_yanit_hazir_o       ( buyruk_yanit_hazir_o ),
    .buyruk_o                   ( getir_buyruk_w ),
    .buyruk_gecerli_o           ( getir_buyruk_gecerli_w )
);

coz coz (
    .clk_i                      ( clk_i ),
    .rst_n_i                    ( rst_n_i ),
    .duraklat_i                 ( duraklat_w ),
    .bosalt_i                   ( bosalt_w ),
    .buyruk_i                   ( getir_buyruk_w ),
    .buyruk_gecerli_i           ( getir_buyruk_gecerli_w ),
    .uop_o                      ( coz_uop_w )
);

yazmac_oku yo (
    .clk_i                      ( clk_i ),
    .rst_n_i                    ( rst_n_i ),
    .duraklat_i                 ( duraklat_w ),
    .bosalt_i                   ( bosalt_w ),
    .uop_i                      ( coz_uop_w ),
    .geri_yaz_i                 ( yurut_geri_yaz_w ),
    .yurut_uop_o                ( yo_yurut_uop_w )
);

yurut yurut (
    .clk_i                      ( clk_i ),
    .rst_n_i                    ( rst_n_i ),
    .yurut_uop_i                ( yo_yurut_uop_w ),
    .l1v_istek_adres_o          ( l1v_istek_adres_o ),
    .l1v_istek_veri_o           ( l1v_istek_veri_o ),
    .l1v_istek_gecerli_o        ( l1v_istek_gecerli_o ),
    .l1v_istek_hazir_i          ( l1v_istek_hazir_i ),
    .duraklat_o                 ( yurut_duraklat_w ),
    .geri_yaz_o                 ( yurut_geri_yaz_w ),
    .yonlendir_o                ( yurut_yonlendir_w )
);

endmodule

/* verification/cekirdek_denetci.sv */
`timescale 1ns/100ps

`include "cekirdek_cfg.svh"

module cekirdek_denetci (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [`CEKIRDEK_PS_BIT-1:0]     buyruk_istek_adres_i,
    input  logic                            buyruk_istek_gecerli_i,
    input  logic                            buyruk_yanit_gecerli_i,
    input  logic                            buyruk_yanit_hazir_i,
    input  logic [`CEKIRDEK_PS_BIT-1:0]     l1v_istek_adres_i,
    input  logic [`CEKIRDEK_VERI_BIT-1:0]   l1v_istek_veri_i,
    input  logic                            l1v_istek_gecerli_i,
    input  logic                            l1v_istek_hazir_i
);

string                          test_ad;
logic [`CEKIRDEK_PS_BIT-1:0]    bek_adres[$];
logic [`CEKIRDEK_VERI_BIT-1:0]  bek_veri[$];
int                             gorulen = 0;
int                             test_hata = 0;
int                             toplam_hata = 0;
int                             gecen = 0;
int                             kalan = 0;
bit                             ilk_istek = 1'b0;
bit                             sifirdan_cikis = 1'b0;

task automatic baslat(input string ad);
    test_ad = ad;
    bek_adres.delete();
    bek_veri.delete();
    gorulen = 0;
    test_hata = 0;
    ilk_istek = 1'b1;
endtask

task automatic ekle(input logic [31:0] adres, input logic [31:0] veri);
    bek_adres.push_back(adres);
    bek_veri.push_back(veri);
endtask

task automatic bitir();
    if (gorulen < bek_adres.size()) begin
        $display("Test %s: %0d expected stores never appeared", test_ad,
                 bek_adres.size() - gorulen);
        test_hata++;
    end
    toplam_hata += test_hata;
    if (test_hata == 0) begin
        gecen++;
        $display("Test %s passed, %0d stores", test_ad, gorulen);
    end else begin
        kalan++;
        $display("Test %s failed, %0d errors", test_ad, test_hata);
    end
endtask

task automatic ozet();
    $display("Tests: %0d passed, %0d failed, %0d errors", gecen, kalan, toplam_hata);
endtask

always @(posedge clk_i) begin
    if (!rst_n_i) begin
        sifirdan_cikis = 1'b1;
    end else begin
        // Outputs must come out of reset idle
        if (sifirdan_cikis && (buyruk_istek_gecerli_i || l1v_istek_gecerli_i)) begin
            $display("Test %s: a request was valid right after reset", test_ad);
            test_hata++;
        end
        sifirdan_cikis = 1'b0;
        if (ilk_istek && buyruk_istek_gecerli_i) begin
            ilk_istek = 1'b0;
            if (buyruk_istek_adres_i !== `CEKIRDEK_RESET_PS) begin
                $display("Error: %s first fetch address expected %h actual %h",
                         test_ad, `CEKIRDEK_RESET_PS, buyruk_istek_adres_i);
                test_hata++;
            end
        end
        // No fetch may enter decode while a store waits
        if (l1v_istek_gecerli_i && !l1v_istek_hazir_i &&
            buyruk_yanit_gecerli_i && buyruk_yanit_hazir_i) begin
            $display("Test %s: an instruction response was taken while a store waited",
                     test_ad);
            test_hata++;
        end
        if (l1v_istek_gecerli_i && l1v_istek_hazir_i) begin
            if (gorulen >= bek_adres.size()) begin
                $display("Test %s: unexpected extra store to %h with data %h",
                         test_ad, l1v_istek_adres_i, l1v_istek_veri_i);
                test_hata++;
            end else begin
                if (l1v_istek_adres_i !== bek_adres[gorulen]) begin
                    $display("Error: %s store %0d address expected %h actual %h",
                             test_ad, gorulen, bek_adres[gorulen], l1v_istek_adres_i);
                    test_hata++;
                end
                if (l1v_istek_veri_i !== bek_veri[gorulen]) begin
                    $display("Error: %s store %0d data expected %h actual %h",
                             test_ad, gorulen, bek_veri[gorulen], l1v_istek_veri_i);
                    test_hata++;
                end
            end
            gorulen++;
        end
    end
end

endmodule

/* verification/cekirdek_tb.sv */
`timescale 1ns/100ps

`include "cekirdek_cfg.svh"

module cekirdek_tb;

logic           clk = 1'b0;
logic           rst_n = 1'b0;
logic [31:0]    buyruk_istek_adres;
logic           buyruk_istek_gecerli;
logic           buyruk_istek_hazir = 1'b0;
logic [31:0]    buyruk_yanit_veri = '0;
logic           buyruk_yanit_gecerli = 1'b0;
logic           buyruk_yanit_hazir;
logic [31:0]    l1v_istek_adres;
logic [31:0]    l1v_istek_veri;
logic           l1v_istek_gecerli;
logic           l1v_istek_hazir = 1'b0;

// Parsed golden tests
string          test_ad[$];
int             buyruk_bas[$];
int             buyruk_say[$];
logic [31:0]    buyruklar[$];
int             sakla_bas[$];
int             sakla_say[$];
logic [31:0]    sakla_adres[$];
logic [31:0]    sakla_veri[$];

logic [31:0]    imem [64];
logic [31:0]    bekleyen[$];
bit             yanit_bitti = 1'b0;
int             gecikme = 0;
int             sinir = 0;
bit             yuklendi = 1'b0;

initial begin
    forever #5 clk = ~clk;
end

cekirdek dut (
    .clk_i                  ( clk ),
    .rst_n_i                ( rst_n ),
    .buyruk_yanit_veri_i    ( buyruk_yanit_veri ),
    .buyruk_yanit_gecerli_i ( buyruk_yanit_gecerli ),
    .buyruk_yanit_hazir_o   ( buyruk_yanit_hazir ),
    .buyruk_istek_adres_o   ( buyruk_istek_adres ),
    .buyruk_istek_gecerli_o ( buyruk_istek_gecerli ),
    .buyruk_istek_hazir_i   ( buyruk_istek_hazir ),
    .l1v_istek_adres_o      ( l1v_istek_adres ),
    .l1v_istek_veri_o       ( l1v_istek_veri ),
    .l1v_istek_gecerli_o    ( l1v_istek_gecerli ),
    .l1v_istek_hazir_i      ( l1v_istek_hazir )
);

cekirdek_denetci denetci (
    .clk_i                  ( clk ),
    .rst_n_i                ( rst_n ),
    .buyruk_istek_adres_i   ( buyruk_istek_adres ),
    .buyruk_istek_gecerli_i ( buyruk_istek_gecerli ),
    .buyruk_yanit_gecerli_i ( buyruk_yanit_gecerli ),
    .buyruk_yanit_hazir_i   ( buyruk_yanit_hazir ),
    .l1v_istek_adres_i      ( l1v_istek_adres ),
    .l1v_istek_veri_i       ( l1v_istek_veri ),
    .l1v_istek_gecerli_i    ( l1v_istek_gecerli ),
    .l1v_istek_hazir_i      ( l1v_istek_hazir )
);

// Instruction memory sees handshakes on the rising edge
always @(posedge clk) begin
    if (rst_n && buyruk_istek_gecerli && buyruk_istek_hazir) begin
        bekleyen.push_back(buyruk_istek_adres);
    end
    if (rst_n && buyruk_yanit_gecerli && buyruk_yanit_hazir) begin
        yanit_bitti = 1'b1;
    end
end

always @(negedge clk) begin
    if (!rst_n) begin
        bekleyen.delete();
        buyruk_yanit_gecerli = 1'b0;
        yanit_bitti = 1'b0;
        gecikme = 0;
        buyruk_istek_hazir = 1'b0;
        l1v_istek_hazir = 1'b0;
    end else begin
        buyruk_istek_hazir = ($urandom_range(0, 2) != 0);
        l1v_istek_hazir = ($urandom_range(0, 3) != 0);
        if (yanit_bitti) begin
            buyruk_yanit_gecerli = 1'b0;
        end
        yanit_bitti = 1'b0;
        if (!buyruk_yanit_gecerli && (bekleyen.size() > 0)) begin
            if (gecikme == 0) begin
                buyruk_yanit_veri = imem[bekleyen.pop_front() >> 2];
                buyruk_yanit_gecerli = 1'b1;
                gecikme = $urandom_range(0, 3);
            end else begin
                gecikme--;
            end
        end
    end
end

task automatic testleri_oku();
    int     fd;
    int     n;
    string  satir;
    string  ad;
    logic [31:0] a;
    logic [31:0] d;
    fd = $fopen("verification/cekirdek_golden.txt", "r");
    if (fd == 0) begin
        $display("Cannot open the golden file");
    end else begin
        while ($fgets(satir, fd) > 0) begin
            if (satir.getc(0) == "T") begin
                n = $sscanf(satir, "T %s", ad);
                test_ad.push_back(ad);
                buyruk_bas.push_back(buyruklar.size());
                buyruk_say.push_back(0);
                sakla_bas.push_back(sakla_adres.size());
                sakla_say.push_back(0);
            end else if (satir.getc(0) == "I") begin
                n = $sscanf(satir, "I %h", a);
                buyruklar.push_back(a);
                buyruk_say[buyruk_say.size()-1]++;
            end else if (satir.getc(0) == "S") begin
                n = $sscanf(satir, "S %h %h", a, d);
                sakla_adres.push_back(a);
                sakla_veri.push_back(d);
                sakla_say[sakla_say.size()-1]++;
            end
        end
        $fclose(fd);
    end
endtask

task automatic program_yukle(input int t);
    for (int i = 0; i < 64; i++) begin
        // Filler is addi x0 x0 carrying its own word index
        imem[i] = {i[11:0], 20'h00013};
    end
    for (int i = 0; i < buyruk_say[t]; i++) begin
        imem[i] = buyruklar[buyruk_bas[t] + i];
    end
endtask

initial begin
    int en_uzun;
    void'($urandom(32'h1cc8a080));
    testleri_oku();
    if (test_ad.size() == 0) begin
        $display("No tests were read from the golden file");
        $display("Regression failed");
    end else begin
        en_uzun = 0;
        foreach (buyruk_say[t]) begin
            if (buyruk_say[t] > en_uzun) begin
                en_uzun = buyruk_say[t];
            end
        end
        sinir = test_ad.size() * (200 * en_uzun + 16 + 50);
        yuklendi = 1'b1;
        foreach (test_ad[t]) begin
            @(negedge clk);
            rst_n = 1'b0;
            program_yukle(t);
            denetci.baslat(test_ad[t]);
            for (int i = 0; i < sakla_say[t]; i++) begin
                denetci.ekle(sakla_adres[sakla_bas[t] + i], sakla_veri[sakla_bas[t] + i]);
            end
            repeat (16) @(negedge clk);
            rst_n = 1'b1;
            while (denetci.gorulen < sakla_say[t]) begin
                @(negedge clk);
            end
            // Window for stray stores
            repeat (50) @(negedge clk);
            denetci.bitir();
        end
        denetci.ozet();
        if (denetci.toplam_hata == 0 && denetci.kalan == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
    end
    $finish;
end

initial begin
    wait (yuklendi);
    repeat (sinir) @(posedge clk);
    $display("Watchdog expired before all tests finished");
    $display("Regression failed");
    $finish;
end

endmodule

/* cekirdek.f */
+incdir+design
design/cekirdek_pkg.sv
design/getir.sv
design/coz.sv
design/yazmac_oku.sv
design/yurut.sv
design/cekirdek.sv
verification/cekirdek_denetci.sv
verification/cekirdek_tb.sv

/* Makefile */
SIM = obj_dir/cekirdek_sim
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f cekirdek.f --top-module cekirdek_tb \
		--Mdir obj_dir -o cekirdek_sim

run: compile
	./$(SIM) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/cekirdek_golden.txt */
# T <name> starts a test, I <hex word> is the next instruction from address 0
# S <hex address> <hex data> is an expected store, in program order
T alu
I 00500093
I ffd00113
I 002081b3
I 00302023
I 40208233
I 00402223
I 0020f2b3
I 0020e333
I 0020c3b3
I 00112433
I 00502423
I 00602623
I 00702823
I 00802a23
I 0000006f
S 00000000 00000002
S 00000004 00000008
S 00000008 00000005
S 0000000c fffffffd
S 00000010 fffffff8
S 00000014 00000001
T branch
I 00700093
I 00700113
I 00208663
I 00102023
I 00102223
I 00209463
I 00202423
I 00100193
I 00309463
I 00102623
I 00308463
I 00c0026f
I 00102823
I 00102a23
I 00402c23
I 00302e23
I 0000006f
S 00000008 00000007
S 00000018 00000030
S 0000001c 00000001
T stall
I 10000093
I 00108113
I 0020a023
I 00110113
I 0020a223
I fe20ae23
I 002101b3
I 0030a423
I 0000006f
S 00000100 00000101
S 00000104 00000102
S 000000fc 00000102
S 00000108 00000204
